/* Makefile */
SRCS := $(shell cat project.f)

obj_dir/Vtb_ddr_wbuf: project.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ddr_wbuf \
	  -f project.f -o Vtb_ddr_wbuf

run: obj_dir/Vtb_ddr_wbuf
	obj_dir/Vtb_ddr_wbuf | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* dv/ddr_wbuf_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_wbuf_checker #(
  parameter int BURST_MAX = 8
) (
  input logic              clk,
  input logic              xrst,
  input logic              ddr_req,
  input ddr_buf_pkg::len_t ddr_len
);
  import ddr_buf_pkg::*;

  // ==============================
  // request shape
  // ==============================

  a_req_single: assert property (@(posedge clk) disable iff (!xrst)
    ddr_req |=> !ddr_req)
    else $error("ddr_req stayed high for two cycles");

  a_len_range: assert property (@(posedge clk) disable iff (!xrst)
    ddr_req |-> (ddr_len >= len_t'(1) && ddr_len <= len_t'(BURST_MAX)))
    else $error("ddr_len out of range with ddr_req high");

  // quiet in reset and the cycle after
  a_reset_quiet: assert property (@(posedge clk)
    !xrst |=> !ddr_req)
    else $error("ddr_req high during or right after reset");

endmodule

bind ddr_wbuf_top ddr_wbuf_checker #(
  .BURST_MAX (BURST_MAX)
) u_checker (
  .clk     (clk),
  .xrst    (xrst),
  .ddr_req (ddr_req),
  .ddr_len (ddr_len)
);

`default_nettype wire

/* dv/tb_ddr_wbuf.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_wbuf;
  import ddr_buf_pkg::*;

  localparam int BURST_MAX  = 8;
  localparam int HALF_WORDS = RATE * BURST_MAX;
  localparam int NROWS      = 8;
  localparam int TIMEOUT    = 100;

  typedef struct packed {
    beat_addr_t  base;
    len_t        len;
    logic [31:0] idle;
  } row_t;

  // base, length in words, idle percent
  row_t rows [NROWS] = '{
    '{24'd16,  16'd64, 32'd0},
    '{24'd100, 16'd70, 32'd0},
    '{24'd200, 16'd1,  32'd0},
    '{24'd37,  16'd3,  32'd30},
    '{24'd300, 16'd33, 32'd0},
    '{24'd64,  16'd32, 32'd50},
    '{24'd250, 16'd64, 32'd40},
    '{24'd5,   16'd70, 32'd25}
  };

  logic                     clk;
  logic                     xrst;
  logic                     write_req;
  beat_addr_t               write_base;
  len_t                     write_len;
  logic                     mem_we;
  logic [IMGSIZE-1:0]       mem_addr;
  word_t                    mem_wdata;
  beat_addr_t               ddr_raddr;
  logic                     ddr_req;
  logic [MEMSIZE+LSB-1:0]   ddr_base;
  len_t                     ddr_len;
  beat_t                    ddr_rdata;

  beat_t       model [512];
  word_t       img_words [128];
  beat_addr_t  exp_base_q [$];
  int          exp_len_q [$];
  logic [31:0] rng;
  int          sealed_cnt;
  int          drained_cnt;
  int          req_cnt;
  int          mismatch_cnt;
  int          other_cnt;

  ddr_wbuf_top #(.BURST_MAX (BURST_MAX)) uut (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ==============================
  // compare tasks
  // ==============================

  task automatic check_beat(input string name, input beat_t exp, input beat_t got);
    if (got !== exp) begin
      $display("Mismatch %s: expected %h, got %h", name, exp, got);
      mismatch_cnt++;
    end
  endtask

  task automatic check_len(input string name, input len_t exp, input len_t got);
    if (got !== exp) begin
      $display("Mismatch %s: expected %h, got %h", name, exp, got);
      mismatch_cnt++;
    end
  endtask

  task automatic check_base(input string name, input logic [MEMSIZE+LSB-1:0] exp,
                            input logic [MEMSIZE+LSB-1:0] got);
    if (got !== exp) begin
      $display("Mismatch %s: expected %h, got %h", name, exp, got);
      mismatch_cnt++;
    end
  endtask

  task automatic finish_run();
    $display("mismatches %0d, other errors %0d, bursts drained %0d",
             mismatch_cnt, other_cnt, drained_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (drained_cnt < sealed_cnt) begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout: burst %0d was not requested and drained in %0d cycles",
                 drained_cnt, TIMEOUT);
        other_cnt++;
        finish_run();
      end
    end
  endtask

  // ==============================
  // image feed and model
  // ==============================

  task automatic run_image(input row_t row);
    int w;
    int left;
    int nbursts;
    for (w = 0; w < int'(row.len); w++) begin
      rng = xorshift32(rng);
      img_words[w] = word_t'(rng[15:0]);
    end
    nbursts = (int'(row.len) + HALF_WORDS - 1) / HALF_WORDS;
    for (w = 0; w < nbursts * BURST_MAX; w++) model[int'(row.base) + w] = '0;
    for (w = 0; w < int'(row.len); w++) begin
      model[int'(row.base) + w / RATE][(w % RATE) * DWIDTH +: DWIDTH] = img_words[w];
    end
    for (w = 0; w < nbursts; w++) begin
      left = int'(row.len) - w * HALF_WORDS;
      exp_base_q.push_back(row.base + beat_addr_t'(w * BURST_MAX));
      exp_len_q.push_back(left >= HALF_WORDS ? BURST_MAX : (left + RATE - 1) / RATE);
    end
    @(posedge clk);
    write_req  <= 1'b1;
    write_base <= row.base;
    write_len  <= row.len;
    w = 0;
    while (w < int'(row.len)) begin
      @(posedge clk);
      write_req <= 1'b0;
      rng = xorshift32(rng);
      if (rng % 32'd100 < row.idle) begin
        mem_we <= 1'b0;
      end else begin
        mem_we    <= 1'b1;
        mem_addr  <= (IMGSIZE'(row.base) << RATELOG) + IMGSIZE'(w);
        mem_wdata <= img_words[w];
        w++;
        if (w % HALF_WORDS == 0 || w == int'(row.len)) begin
          sealed_cnt++;
          // a short next half would seal before this drain ends
          if (int'(row.len) - w < HALF_WORDS) begin
            @(posedge clk);
            mem_we <= 1'b0;
            wait_drained();
          end
        end
      end
    end
  endtask

  // ==============================
  // ddr master drain
  // ==============================

  // every request pulse, also those during a drain
  always @(posedge clk) begin
    if (xrst === 1'b1 && ddr_req === 1'b1) begin
      req_cnt <= req_cnt + 1;
    end
  end

  initial begin : drain
    beat_addr_t bbase;
    int         blen;
    forever begin
      @(posedge clk);
      if (xrst === 1'b1 && ddr_req === 1'b1) begin
        if (exp_base_q.size() == 0) begin
          $display("ddr_req seen with no burst outstanding");
          other_cnt++;
        end else begin
          bbase = exp_base_q.pop_front();
          blen  = exp_len_q.pop_front();
          check_base("ddr_base", (MEMSIZE+LSB)'(bbase) << LSB, ddr_base);
          check_len("ddr_len", len_t'(blen), ddr_len);
          // read data trails the address by one cycle
          for (int i = 0; i < blen + 2; i++) begin
            if (i > 0) @(posedge clk);
            if (i >= 2) check_beat("ddr_rdata", model[int'(bbase) + i - 2], ddr_rdata);
            if (i < blen) ddr_raddr <= bbase + beat_addr_t'(i);
          end
          drained_cnt <= drained_cnt + 1;
        end
      end
    end
  end

  initial begin
    clk          = 1'b0;
    xrst         = 1'b0;
    write_req    = 1'b0;
    write_base   = '0;
    write_len    = '0;
    mem_we       = 1'b0;
    mem_addr     = '0;
    mem_wdata    = '0;
    ddr_raddr    = '0;
    rng          = 32'd94;
    sealed_cnt   = 0;
    drained_cnt  = 0;
    req_cnt      = 0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    repeat (16) @(posedge clk);
    xrst <= 1'b1;
    repeat (4) @(posedge clk);
    for (int r = 0; r < NROWS; r++) run_image(rows[r]);
    repeat (20) @(posedge clk);
    if (req_cnt != sealed_cnt) begin
      $display("%0d ddr_req pulses seen for %0d sealed halves", req_cnt, sealed_cnt);
      other_cnt++;
    end
    finish_run();
  end

endmodule

`default_nettype wire

/* project.f */
src/ddr_buf_pkg.sv
src/beat_mem.sv
src/word_packer.sv
src/pingpong_buffer.sv
src/burst_issuer.sv
src/ddr_wbuf_top.sv
dv/ddr_wbuf_checker.sv
dv/tb_ddr_wbuf.sv

/* src/beat_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module beat_mem #(
  parameter int DEPTH = 8
) (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  ddr_buf_pkg::beat_t       wdata,
  output ddr_buf_pkg::beat_t       rdata
);
  import ddr_buf_pkg::*;

  beat_t ram [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      ram[addr] <= wdata;
    end
  end

  // registered read, old contents on a write
  always_ff @(posedge clk) begin
    if (!xrst) begin
      rdata <= '0;
    end else begin
      rdata <= ram[addr];
    end
  end

endmodule

`default_nettype wire

/* src/burst_issuer.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_issuer #(
  parameter int BURST_MAX = 8
) (
  input  logic                                            clk,
  input  logic                                            xrst,
  input  ddr_buf_pkg::burst_t                             seal,
  input  logic                                            seal_valid,
  input  ddr_buf_pkg::beat_addr_t                         ddr_raddr,
  output logic                                            ddr_req,
  output logic [ddr_buf_pkg::MEMSIZE+ddr_buf_pkg::LSB-1:0] ddr_base,
  output ddr_buf_pkg::len_t                               ddr_len,
  output logic                                            drain_bank,
  output ddr_buf_pkg::len_t                               drain_idx
);
  import ddr_buf_pkg::*;

  localparam int AW = $clog2(BURST_MAX);

  beat_addr_t drain_base;
  beat_addr_t raddr_off;

  // ==============================
  // burst request
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ddr_req <= 1'b0;
    end else begin
      ddr_req <= seal_valid;
    end
  end

  // held until the next seal
  always_ff @(posedge clk) begin
    if (!xrst) begin
      ddr_base <= '0;
      ddr_len  <= '0;
    end else if (seal_valid) begin
      ddr_base <= {seal.base, {LSB{1'b0}}};
      ddr_len  <= seal.len;
    end
  end

  // ==============================
  // draining half
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      drain_bank <= 1'b0;
      drain_base <= '0;
    end else if (seal_valid) begin
      drain_bank <= seal.bank;
      drain_base <= seal.base;
    end
  end

  // master beat address to index inside the half
  assign raddr_off = ddr_raddr - drain_base;
  assign drain_idx = len_t'(raddr_off[AW-1:0]);

endmodule

`default_nettype wire

/* src/ddr_buf_pkg.sv */
`default_nettype none

package ddr_buf_pkg;

  // ==============================
  // widths and rates
  // ==============================

  localparam int DWIDTH  = 16;
  localparam int RATE    = 4;
  localparam int RATELOG = 2;
  localparam int BWIDTH  = DWIDTH * RATE;

  // beat address and its byte shift
  localparam int MEMSIZE = 24;
  localparam int LSB     = 3;

  // word address, beat address plus lane bits
  localparam int IMGSIZE = MEMSIZE + RATELOG;
  localparam int LWIDTH  = 16;

  // ==============================
  // types
  // ==============================

  typedef logic signed [DWIDTH-1:0] word_t;
  typedef logic [BWIDTH-1:0]        beat_t;
  typedef logic [MEMSIZE-1:0]       beat_addr_t;
  typedef logic [LWIDTH-1:0]        len_t;

  // one beat write into a half
  typedef struct packed {
    logic  we;
    logic  bank;
    len_t  idx;
    beat_t data;
  } beat_wr_t;

  // sealed half, len in beats
  typedef struct packed {
    logic       bank;
    beat_addr_t base;
    len_t       len;
  } burst_t;

endpackage

`default_nettype wire

/* src/ddr_wbuf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_wbuf_top #(
  parameter int BURST_MAX = 8
) (
  input  logic                                            clk,
  input  logic                                            xrst,
  input  logic                                            write_req,
  input  ddr_buf_pkg::beat_addr_t                         write_base,
  input  ddr_buf_pkg::len_t                               write_len,
  input  logic                                            mem_we,
  input  logic [ddr_buf_pkg::IMGSIZE-1:0]                 mem_addr,
  input  ddr_buf_pkg::word_t                              mem_wdata,
  input  ddr_buf_pkg::beat_addr_t                         ddr_raddr,
  output logic                                            ddr_req,
  output logic [ddr_buf_pkg::MEMSIZE+ddr_buf_pkg::LSB-1:0] ddr_base,
  output ddr_buf_pkg::len_t                               ddr_len,
  output ddr_buf_pkg::beat_t                              ddr_rdata
);
  import ddr_buf_pkg::*;

  beat_wr_t fill;
  burst_t   seal;
  logic     seal_valid;
  logic     drain_bank;
  len_t     drain_idx;

  // ==============================
  // image side
  // ==============================

  word_packer #(
    .BURST_MAX (BURST_MAX)
  ) u_packer (
    .clk        (clk),
    .xrst       (xrst),
    .write_req  (write_req),
    .write_base (write_base),
    .write_len  (write_len),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .fill       (fill),
    .seal       (seal),
    .seal_valid (seal_valid)
  );

  // ==============================
  // ping-pong halves
  // ==============================

  pingpong_buffer #(
    .BURST_MAX (BURST_MAX)
  ) u_buffer (
    .clk        (clk),
    .xrst       (xrst),
    .fill       (fill),
    .drain_bank (drain_bank),
    .drain_idx  (drain_idx),
    .drain_data (ddr_rdata)
  );

  // ==============================
  // ddr side
  // ==============================

  burst_issuer #(
    .BURST_MAX (BURST_MAX)
  ) u_issuer (
    .clk        (clk),
    .xrst       (xrst),
    .seal       (seal),
    .seal_valid (seal_valid),
    .ddr_raddr  (ddr_raddr),
    .ddr_req    (ddr_req),
    .ddr_base   (ddr_base),
    .ddr_len    (ddr_len),
    .drain_bank (drain_bank),
    .drain_idx  (drain_idx)
  );

endmodule

`default_nettype wire

/* src/pingpong_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module pingpong_buffer #(
  parameter int BURST_MAX = 8
) (
  input  logic                  clk,
  input  logic                  xrst,
  input  ddr_buf_pkg::beat_wr_t fill,
  input  logic                  drain_bank,
  input  ddr_buf_pkg::len_t     drain_idx,
  output ddr_buf_pkg::beat_t    drain_data
);
  import ddr_buf_pkg::*;

  localparam int AW = $clog2(BURST_MAX);

  logic          we_a;
  logic          we_b;
  logic [AW-1:0] addr_a;
  logic [AW-1:0] addr_b;
  beat_t         rdata_a;
  beat_t         rdata_b;
  logic          sel_q;

  // ==============================
  // fill steering
  // ==============================

  assign we_a = fill.we && !fill.bank;
  assign we_b = fill.we && fill.bank;

  // a port not taking a write reads for the drain side
  assign addr_a = we_a ? fill.idx[AW-1:0] : drain_idx[AW-1:0];
  assign addr_b = we_b ? fill.idx[AW-1:0] : drain_idx[AW-1:0];

  beat_mem #(
    .DEPTH (BURST_MAX)
  ) bank_a (
    .clk   (clk),
    .xrst  (xrst),
    .we    (we_a),
    .addr  (addr_a),
    .wdata (fill.data),
    .rdata (rdata_a)
  );

  beat_mem #(
    .DEPTH (BURST_MAX)
  ) bank_b (
    .clk   (clk),
    .xrst  (xrst),
    .we    (we_b),
    .addr  (addr_b),
    .wdata (fill.data),
    .rdata (rdata_b)
  );

  // ==============================
  // drain select
  // ==============================

  // delayed to match the ram read
  always_ff @(posedge clk) begin
    if (!xrst) begin
      sel_q <= 1'b0;
    end else begin
      sel_q <= drain_bank;
    end
  end

  assign drain_data = sel_q ? rdata_b : rdata_a;

endmodule

`default_nettype wire

/* src/word_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module word_packer #(
  parameter int BURST_MAX = 8
) (
  input  logic                            clk,
  input  logic                            xrst,
  input  logic                            write_req,
  input  ddr_buf_pkg::beat_addr_t         write_base,
  input  ddr_buf_pkg::len_t               write_len,
  input  logic                            mem_we,
  input  logic [ddr_buf_pkg::IMGSIZE-1:0] mem_addr,
  input  ddr_buf_pkg::word_t              mem_wdata,
  output ddr_buf_pkg::beat_wr_t           fill,
  output ddr_buf_pkg::burst_t             seal,
  output logic                            seal_valid
);
  import ddr_buf_pkg::*;

  beat_addr_t         burst_base;
  len_t               remain;
  len_t               beat_cnt;
  logic               bank;
  beat_t              acc;
  beat_t              next_beat;
  logic [RATELOG-1:0] lane;
  beat_addr_t         beat_off;
  logic               last_word;
  logic               beat_done;
  logic               half_done;
  logic               fill_we;
  logic               fill_bank;
  len_t               fill_idx;
  beat_t              fill_data;

  // ==============================
  // lane packing
  // ==============================

  assign lane      = mem_addr[RATELOG-1:0];
  assign beat_off  = mem_addr[IMGSIZE-1:RATELOG] - burst_base;
  assign last_word = remain == len_t'(1);
  assign beat_done = mem_we && (lane == RATELOG'(RATE - 1) || last_word);
  assign half_done = beat_done && (beat_cnt == len_t'(BURST_MAX - 1) || last_word);

  always_comb begin
    next_beat = acc;
    next_beat[lane*DWIDTH +: DWIDTH] = mem_wdata;
  end

  // cleared per beat so a short last beat has zero lanes
  always_ff @(posedge clk) begin
    if (write_req) begin
      acc <= '0;
    end else if (mem_we) begin
      acc <= beat_done ? '0 : next_beat;
    end
  end

  // ==============================
  // image and half tracking
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      burst_base <= '0;
      remain     <= '0;
      beat_cnt   <= '0;
      bank       <= 1'b0;
    end else if (write_req) begin
      burst_base <= write_base;
      remain     <= write_len;
      beat_cnt   <= '0;
    end else if (mem_we) begin
      remain <= remain - len_t'(1);
      if (half_done) begin
        beat_cnt   <= '0;
        burst_base <= burst_base + beat_addr_t'(BURST_MAX);
        bank       <= ~bank;
      end else if (beat_done) begin
        beat_cnt <= beat_cnt + len_t'(1);
      end
    end
  end

  // ==============================
  // outputs to buffer and issuer
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      fill_we    <= 1'b0;
      seal_valid <= 1'b0;
    end else begin
      fill_we    <= beat_done;
      seal_valid <= half_done;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_done) begin
      fill_bank <= bank;
      fill_idx  <= len_t'(beat_off);
      fill_data <= next_beat;
    end
    // length rounds up, the sealing beat included
    if (half_done) begin
      seal <= '{bank: bank, base: burst_base, len: beat_cnt + len_t'(1)};
    end
  end

  assign fill = '{we: fill_we, bank: fill_bank, idx: fill_idx, data: fill_data};

endmodule

`default_nettype wire
